/* hw/socket_mem_pkg.sv */
/*
 * Memory-bus widths of the core side
 * Core request and response structs
 */

`default_nettype none

package socket_mem_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int MEM_DATA_W = 32;
    localparam int MEM_ADDR_W = 32;
    localparam int MEM_BE_W   = MEM_DATA_W / 8;    // One enable per byte lane

    //////////////////////////////////////////////////
    // Core side structs
    //////////////////////////////////////////////////

    // Request from the core held steady until gnt
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_BE_W-1:0]   be;
        logic [MEM_DATA_W-1:0] wdata;
    } mem_req_t;

    // Answer to the core
    typedef struct packed {
        logic                  gnt;      // Same cycle as req when idle
        logic                  valid;    // One cycle per accepted request
        logic [MEM_DATA_W-1:0] rdata;    // Reads only
        logic                  error;    // AXI response was not OKAY
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hw/socket_axi_pkg.sv */
/*
 * AXI4-Lite channel structs of the bus side
 * Master request and slave response bundles, response codes
 */

`default_nettype none

package socket_axi_pkg;

    import socket_mem_pkg::*;

    //////////////////////////////////////////////////
    // Response codes
    //////////////////////////////////////////////////

    localparam int AXI_RESP_W = 2;

    localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [AXI_RESP_W-1:0] AXI_RESP_SLVERR = 2'b10;
    localparam logic [AXI_RESP_W-1:0] AXI_RESP_DECERR = 2'b11;

    //////////////////////////////////////////////////
    // Channels
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_DATA_W-1:0] data;
        logic [MEM_BE_W-1:0]   strb;
    } axi_w_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_DATA_W-1:0] data;
        logic [AXI_RESP_W-1:0] resp;
    } axi_r_t;

    typedef struct packed {
        logic                  valid;
        logic [AXI_RESP_W-1:0] resp;
    } axi_b_t;

    // Master to slave
    typedef struct packed {
        axi_aw_t aw;
        axi_w_t  w;
        axi_ar_t ar;
        logic    bready;
        logic    rready;
    } axi_req_t;

    // Slave to master
    typedef struct packed {
        logic   awready;
        logic   wready;
        logic   arready;
        axi_r_t r;
        axi_b_t b;
    } axi_rsp_t;

endpackage

`default_nettype wire

/* hw/axi_read_channel.sv */
/*
 * AXI4-Lite read FSM for one bridge
 * Drives AR, waits on R and reports a done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module axi_read_channel
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  start_i,
    input  wire logic [MEM_ADDR_W-1:0] addr_i,
    output axi_ar_t                    ar_o,
    input  wire logic                  arready_i,
    input  wire axi_r_t                r_i,
    output logic                       rready_o,
    output logic                       done_o,
    output logic [MEM_DATA_W-1:0]      rdata_o,     // Bus byte order
    output logic                       error_o
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e             state_q;
    logic [MEM_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    if (start_i) state_q <= RD_ADDR;
                end
                RD_ADDR: begin
                    if (arready_i) state_q <= RD_DATA;    // AR accepted
                end
                RD_DATA: begin
                    if (r_i.valid) state_q <= RD_IDLE;
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // Address held for the whole AR phase
    always_ff @(posedge clk_i) begin
        if (start_i) addr_q <= addr_i;
    end

    assign ar_o     = '{valid: state_q == RD_ADDR, addr: addr_q};
    assign rready_o = (state_q == RD_DATA);

    // Done in the R handshake cycle itself
    assign done_o  = rready_o && r_i.valid;
    assign rdata_o = r_i.data;
    assign error_o = (r_i.resp != AXI_RESP_OKAY);

    a_ar_stable : assert property (@(posedge clk_i) disable iff (reset_i)
        ar_o.valid && !arready_i |=> ar_o.valid && $stable(ar_o.addr));

endmodule

`default_nettype wire

/* hw/axi_write_channel.sv */
/*
 * AXI4-Lite write FSM for one bridge
 * AW and W issued together, then B collected into a done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module axi_write_channel
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  start_i,
    input  wire logic [MEM_ADDR_W-1:0] addr_i,
    input  wire logic [MEM_DATA_W-1:0] wdata_i,     // Bus byte order
    input  wire logic [MEM_BE_W-1:0]   wstrb_i,
    output axi_aw_t                    aw_o,
    input  wire logic                  awready_i,
    output axi_w_t                     w_o,
    input  wire logic                  wready_i,
    input  wire axi_b_t                b_i,
    output logic                       bready_o,
    output logic                       done_o,
    output logic                       error_o
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_RESP
    } wr_state_e;

    wr_state_e             state_q;
    logic                  aw_pend_q;
    logic                  w_pend_q;
    logic                  aw_left;
    logic                  w_left;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic [MEM_DATA_W-1:0] wdata_q;
    logic [MEM_BE_W-1:0]   wstrb_q;

    // Still waiting after this cycle
    assign aw_left = aw_pend_q && !awready_i;
    assign w_left  = w_pend_q && !wready_i;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= WR_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (start_i) begin
                        state_q   <= WR_ADDR;
                        aw_pend_q <= 1'b1;
                        w_pend_q  <= 1'b1;
                    end
                end
                WR_ADDR: begin
                    // AW and W may complete in either order
                    aw_pend_q <= aw_left;
                    w_pend_q  <= w_left;
                    if (!aw_left && !w_left) state_q <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_i.valid) state_q <= WR_IDLE;
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Payload captured at start
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
        end
    end

    assign aw_o     = '{valid: aw_pend_q, addr: addr_q};
    assign w_o      = '{valid: w_pend_q, data: wdata_q, strb: wstrb_q};
    assign bready_o = (state_q == WR_RESP);

    assign done_o  = bready_o && b_i.valid;    // B handshake cycle
    assign error_o = (b_i.resp != AXI_RESP_OKAY);

    a_w_stable : assert property (@(posedge clk_i) disable iff (reset_i)
        w_o.valid && !wready_i |=> w_o.valid && $stable(w_o.data) && $stable(w_o.strb));

endmodule

`default_nettype wire

/* hw/mem_to_axi_bridge.sv */
/*
 * Memory-bus to AXI4-Lite bridge with one transaction in flight
 * Grant logic, byte-lane reversal and registered response
 */

`timescale 1ns/1ps
`default_nettype none

module mem_to_axi_bridge
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
#(
    parameter bit HAS_WRITE = 1'b1
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire mem_req_t mem_req_i,
    output mem_rsp_t      mem_rsp_o,
    output axi_req_t      axi_o,
    input  wire axi_rsp_t axi_i
);

    // Reverse byte lanes between core and bus order
    function automatic logic [MEM_DATA_W-1:0] swap_word(input logic [MEM_DATA_W-1:0] word);
        logic [MEM_DATA_W-1:0] res;
        for (int i = 0; i < MEM_BE_W; i++) begin
            res[8*i +: 8] = word[8*(MEM_BE_W-1-i) +: 8];
        end
        return res;
    endfunction

    function automatic logic [MEM_BE_W-1:0] swap_be(input logic [MEM_BE_W-1:0] be);
        logic [MEM_BE_W-1:0] res;
        for (int i = 0; i < MEM_BE_W; i++) begin
            res[i] = be[MEM_BE_W-1-i];
        end
        return res;
    endfunction

    logic                  busy_q;
    logic                  gnt;
    logic                  wr_req;
    logic                  start_rd;
    logic                  valid_q;
    logic [MEM_DATA_W-1:0] rdata_q;
    logic                  error_q;
    logic                  rd_done;
    logic [MEM_DATA_W-1:0] rd_data;
    logic                  rd_error;
    logic                  wr_done;
    logic                  wr_error;
    axi_aw_t               aw;
    axi_w_t                w;
    axi_ar_t               ar;
    logic                  rready;
    logic                  bready;

    //////////////////////////////////////////////////
    // Grant and busy tracking
    //////////////////////////////////////////////////

    assign gnt      = mem_req_i.req && !busy_q;
    assign wr_req   = HAS_WRITE && mem_req_i.we;
    assign start_rd = gnt && !wr_req;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_done || wr_done;
            if (valid_q) begin
                busy_q <= 1'b0;    // Free again after the response cycle
            end else if (gnt) begin
                busy_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_done) rdata_q <= swap_word(rd_data);
        if (rd_done || wr_done) error_q <= rd_done ? rd_error : wr_error;
    end

    assign mem_rsp_o = '{gnt: gnt, valid: valid_q, rdata: rdata_q, error: error_q};
    assign axi_o     = '{aw: aw, w: w, ar: ar, bready: bready, rready: rready};

    //////////////////////////////////////////////////
    // Channel FSMs
    //////////////////////////////////////////////////

    axi_read_channel read_channel_u (
        .clk_i     ( clk_i         ),
        .reset_i   ( reset_i       ),
        .start_i   ( start_rd      ),
        .addr_i    ( mem_req_i.addr ),
        .ar_o      ( ar            ),
        .arready_i ( axi_i.arready ),
        .r_i       ( axi_i.r       ),
        .rready_o  ( rready        ),
        .done_o    ( rd_done       ),
        .rdata_o   ( rd_data       ),
        .error_o   ( rd_error      )
    );

    generate
        if (HAS_WRITE) begin : g_write
            logic start_wr;

            assign start_wr = gnt && wr_req;

            axi_write_channel write_channel_u (
                .clk_i     ( clk_i                   ),
                .reset_i   ( reset_i                 ),
                .start_i   ( start_wr                ),
                .addr_i    ( mem_req_i.addr          ),
                .wdata_i   ( swap_word(mem_req_i.wdata) ),
                .wstrb_i   ( swap_be(mem_req_i.be)   ),
                .aw_o      ( aw                      ),
                .awready_i ( axi_i.awready           ),
                .w_o       ( w                       ),
                .wready_i  ( axi_i.wready            ),
                .b_i       ( axi_i.b                 ),
                .bready_o  ( bready                  ),
                .done_o    ( wr_done                 ),
                .error_o   ( wr_error                )
            );
        end else begin : g_read_only
            // Write side tied off
            assign aw       = '0;
            assign w        = '0;
            assign bready   = 1'b0;
            assign wr_done  = 1'b0;
            assign wr_error = 1'b0;

            a_no_write : assert property (@(posedge clk_i) disable iff (reset_i)
                gnt |-> !mem_req_i.we);
        end
    endgenerate

    // Response only for a transaction that was granted earlier
    a_valid_busy : assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rsp_o.valid |-> busy_q && $past(busy_q));

endmodule

`default_nettype wire

/* hw/mem_axi_socket.sv */
/*
 * Socket top with instruction and data bridges
 */

`timescale 1ns/1ps
`default_nettype none

module mem_axi_socket
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     reset_i,

    // Instruction port, read only
    input  wire mem_req_t instr_req_i,
    output mem_rsp_t      instr_rsp_o,
    output axi_req_t      instr_axi_o,
    input  wire axi_rsp_t instr_axi_i,

    // Data port
    input  wire mem_req_t data_req_i,
    output mem_rsp_t      data_rsp_o,
    output axi_req_t      data_axi_o,
    input  wire axi_rsp_t data_axi_i
);

    //////////////////////////////////////////////////
    // Instruction bridge
    //////////////////////////////////////////////////

    mem_to_axi_bridge #(
        .HAS_WRITE ( 1'b0 )
    ) instr_bridge_u (
        .clk_i     ( clk_i       ),
        .reset_i   ( reset_i     ),
        .mem_req_i ( instr_req_i ),
        .mem_rsp_o ( instr_rsp_o ),
        .axi_o     ( instr_axi_o ),
        .axi_i     ( instr_axi_i )
    );

    //////////////////////////////////////////////////
    // Data bridge
    //////////////////////////////////////////////////

    mem_to_axi_bridge #(
        .HAS_WRITE ( 1'b1 )
    ) data_bridge_u (
        .clk_i     ( clk_i      ),
        .reset_i   ( reset_i    ),
        .mem_req_i ( data_req_i ),
        .mem_rsp_o ( data_rsp_o ),
        .axi_o     ( data_axi_o ),    // Full read/write AXI4-Lite
        .axi_i     ( data_axi_i )
    );

endmodule

`default_nettype wire

/* dv/axi_mem_model.sv */
/*
 * AXI4-Lite slave model with two ports on one 256-word memory
 * Random ready stalls, SLVERR for addresses with bit 31 set
 */

`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
(
    input  wire logic           clk_i,
    input  wire logic           reset_i,
    input  wire axi_req_t [1:0] axi_req_i,    // 0 instruction, 1 data
    output axi_rsp_t [1:0]      axi_rsp_o
);

    localparam int WORDS = 256;

    logic [MEM_DATA_W-1:0]      mem [WORDS];
    logic [31:0]                rnd_q;
    logic [1:0]                 r_pend_q;
    logic [1:0]                 aw_got_q;
    logic [1:0]                 w_got_q;
    logic [1:0]                 b_pend_q;
    logic [1:0][MEM_DATA_W-1:0] r_data_q;
    logic [1:0][MEM_DATA_W-1:0] w_data_q;
    logic [1:0][MEM_ADDR_W-1:0] aw_addr_q;
    logic [1:0][MEM_BE_W-1:0]   w_strb_q;
    logic [1:0][AXI_RESP_W-1:0] r_resp_q;
    logic [1:0][AXI_RESP_W-1:0] b_resp_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Preload pattern using every bit of the word index
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx + 8'h11, idx};
    endfunction

    //////////////////////////////////////////////////
    // Ready stalls and response channels
    //////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            axi_rsp_o[p].arready = (rnd_q[6*p +: 2] != 2'b00) && !r_pend_q[p];
            axi_rsp_o[p].awready = (rnd_q[6*p+2 +: 2] != 2'b00) && !aw_got_q[p] && !b_pend_q[p];
            axi_rsp_o[p].wready  = (rnd_q[6*p+4 +: 2] != 2'b00) && !w_got_q[p] && !b_pend_q[p];
            axi_rsp_o[p].r = '{valid: r_pend_q[p], data: r_data_q[p], resp: r_resp_q[p]};
            axi_rsp_o[p].b = '{valid: b_pend_q[p], resp: b_resp_q[p]};
        end
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            rnd_q    <= 32'h18bf;
            r_pend_q <= '0;
            aw_got_q <= '0;
            w_got_q  <= '0;
            b_pend_q <= '0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i] = fill_word(8'(i));
            end
        end else begin
            rnd_q <= xorshift(rnd_q);
            for (int p = 0; p < 2; p++) begin
                if (axi_req_i[p].ar.valid && axi_rsp_o[p].arready) begin
                    r_pend_q[p] <= 1'b1;
                    r_resp_q[p] <= axi_req_i[p].ar.addr[31] ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                    r_data_q[p] <= axi_req_i[p].ar.addr[31] ? '0 : mem[axi_req_i[p].ar.addr[9:2]];
                end else if (r_pend_q[p] && axi_req_i[p].rready) begin
                    r_pend_q[p] <= 1'b0;
                end

                // AW and W collected in any order
                if (axi_req_i[p].aw.valid && axi_rsp_o[p].awready) begin
                    aw_got_q[p]  <= 1'b1;
                    aw_addr_q[p] <= axi_req_i[p].aw.addr;
                end
                if (axi_req_i[p].w.valid && axi_rsp_o[p].wready) begin
                    w_got_q[p]  <= 1'b1;
                    w_data_q[p] <= axi_req_i[p].w.data;
                    w_strb_q[p] <= axi_req_i[p].w.strb;
                end

                if (aw_got_q[p] && w_got_q[p]) begin
                    aw_got_q[p] <= 1'b0;
                    w_got_q[p]  <= 1'b0;
                    b_pend_q[p] <= 1'b1;
                    b_resp_q[p] <= aw_addr_q[p][31] ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                    if (!aw_addr_q[p][31]) begin
                        for (int b = 0; b < MEM_BE_W; b++) begin
                            if (w_strb_q[p][b]) begin
                                mem[aw_addr_q[p][9:2]][8*b +: 8] = w_data_q[p][8*b +: 8];
                            end
                        end
                    end
                end else if (b_pend_q[p] && axi_req_i[p].bready) begin
                    b_pend_q[p] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/socket_tb.sv */
/*
 * Testbench for the memory-bus to AXI4-Lite socket
 * Stimulus table run on both ports at once, reference memory, response checks
 */

`timescale 1ns/1ps
`default_nettype none

module socket_tb
    import socket_mem_pkg::*;
    import socket_axi_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int TIMEOUT     = 100;    // Cycles per wait
    localparam int N_ENTRIES   = 17;

    typedef struct packed {
        logic                  port;    // 0 instruction, 1 data
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_BE_W-1:0]   be;
        logic [MEM_DATA_W-1:0] wdata;
    } entry_t;

    logic                  clk;
    logic                  reset;
    mem_req_t [1:0]        core_req;
    mem_rsp_t [1:0]        core_rsp;
    axi_req_t [1:0]        bus_req;
    axi_rsp_t [1:0]        bus_rsp;
    mem_rsp_t [1:0]        seen_q;      // Core responses at the last rising edge
    axi_w_t                last_w_q;    // Last W beat accepted on the data port
    entry_t                stim [N_ENTRIES];
    logic [MEM_DATA_W-1:0] ref_mem [256];
    bit [1:0]              busy;
    int                    gnt_cnt [2];
    int                    valid_cnt [2];

    mem_axi_socket dut_i (
        .clk_i       ( clk         ),
        .reset_i     ( reset       ),
        .instr_req_i ( core_req[0] ),
        .instr_rsp_o ( core_rsp[0] ),
        .instr_axi_o ( bus_req[0]  ),
        .instr_axi_i ( bus_rsp[0]  ),
        .data_req_i  ( core_req[1] ),
        .data_rsp_o  ( core_rsp[1] ),
        .data_axi_o  ( bus_req[1]  ),
        .data_axi_i  ( bus_rsp[1]  )
    );

    axi_mem_model mem_u (
        .clk_i     ( clk     ),
        .reset_i   ( reset   ),
        .axi_req_i ( bus_req ),
        .axi_rsp_o ( bus_rsp )
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx + 8'h11, idx};
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [3:0] swap_strb(input logic [3:0] be);
        return {be[0], be[1], be[2], be[3]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at time %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp,
                             input bit cmp_rdata);
        if (!cmp_rdata) exp.rdata = got.rdata;    // Writes and error reads
        if (got !== exp) begin
            report_failure($sformatf("Error at time %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_axi_w(input string name, input axi_w_t got, input axi_w_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at time %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_idle();
        string nm;
        for (int p = 0; p < 2; p++) begin
            nm = (p == 0) ? "instr" : "data";
            check_bit({nm, "_rsp_o.gnt"}, core_rsp[p].gnt, 1'b0);
            check_bit({nm, "_rsp_o.valid"}, core_rsp[p].valid, 1'b0);
            check_bit({nm, "_axi_o.aw.valid"}, bus_req[p].aw.valid, 1'b0);
            check_bit({nm, "_axi_o.w.valid"}, bus_req[p].w.valid, 1'b0);
            check_bit({nm, "_axi_o.ar.valid"}, bus_req[p].ar.valid, 1'b0);
            check_bit({nm, "_axi_o.rready"}, bus_req[p].rready, 1'b0);
            check_bit({nm, "_axi_o.bready"}, bus_req[p].bready, 1'b0);
        end
    endtask

    // One valid per grant, and no grant while a transaction is open
    always @(posedge clk) begin
        seen_q <= core_rsp;
        if (bus_req[1].w.valid && bus_rsp[1].wready) last_w_q <= bus_req[1].w;
        if (reset) begin
            busy = '0;
            gnt_cnt = '{0, 0};
            valid_cnt = '{0, 0};
        end else begin
            // Read-only instruction bridge keeps its write side quiet
            check_bit("instr_axi_o.aw.valid", bus_req[0].aw.valid, 1'b0);
            check_bit("instr_axi_o.w.valid", bus_req[0].w.valid, 1'b0);
            check_bit("instr_axi_o.bready", bus_req[0].bready, 1'b0);
            for (int p = 0; p < 2; p++) begin
                if (core_rsp[p].gnt && busy[p]) begin
                    report_failure($sformatf("Port %0d was granted while busy", p));
                end
                if (core_rsp[p].valid && !busy[p]) begin
                    report_failure($sformatf("Port %0d gave valid with nothing open", p));
                end
                if (core_rsp[p].gnt) begin
                    busy[p] = 1'b1;
                    gnt_cnt[p] = gnt_cnt[p] + 1;
                end
                if (core_rsp[p].valid) begin
                    busy[p] = 1'b0;
                    valid_cnt[p] = valid_cnt[p] + 1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic load_stimulus();
        // port, we, addr, be, wdata
        stim[0]  = '{1'b1, 1'b1, 32'h0000_0010, 4'hf, 32'h1122_3344};
        stim[1]  = '{1'b0, 1'b0, 32'h0000_0000, 4'hf, 32'h0};
        stim[2]  = '{1'b1, 1'b0, 32'h0000_0010, 4'hf, 32'h0};    // Read back full write
        stim[3]  = '{1'b0, 1'b0, 32'h0000_0004, 4'hf, 32'h0};
        stim[4]  = '{1'b1, 1'b1, 32'h0000_0024, 4'h3, 32'ha1b2_c3d4};
        stim[5]  = '{1'b1, 1'b0, 32'h0000_0024, 4'hf, 32'h0};
        stim[6]  = '{1'b0, 1'b0, 32'h0000_0100, 4'hf, 32'h0};
        stim[7]  = '{1'b1, 1'b1, 32'h0000_0038, 4'h8, 32'h5566_7788};
        stim[8]  = '{1'b1, 1'b0, 32'h0000_0038, 4'hf, 32'h0};
        stim[9]  = '{1'b0, 1'b0, 32'h8000_0040, 4'hf, 32'h0};    // Error region
        stim[10] = '{1'b1, 1'b1, 32'h8000_0010, 4'hf, 32'hdead_beef};
        stim[11] = '{1'b1, 1'b0, 32'h8000_0010, 4'hf, 32'h0};
        stim[12] = '{1'b1, 1'b0, 32'h0000_0010, 4'hf, 32'h0};    // Unchanged by error write
        stim[13] = '{1'b0, 1'b0, 32'h0000_0200, 4'hf, 32'h0};
        stim[14] = '{1'b1, 1'b1, 32'h0000_03fc, 4'h6, 32'h0bad_f00d};
        stim[15] = '{1'b1, 1'b0, 32'h0000_03fc, 4'hf, 32'h0};
        stim[16] = '{1'b0, 1'b0, 32'h0000_03f8, 4'hf, 32'h0};
    endtask

    task automatic drive_req(input bit port, input entry_t e);
        core_req[port] = '{req: 1'b1, we: e.we, addr: e.addr, be: e.be, wdata: e.wdata};
    endtask

    task automatic wait_gnt(input bit port);
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (seen_q[port].gnt) return;
        end
        report_failure($sformatf("Timeout: request on port %0d was never granted", port));
    endtask

    task automatic wait_valid(input bit port);
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (seen_q[port].valid) return;
        end
        report_failure($sformatf("Timeout: no valid on port %0d after the grant", port));
    endtask

    task automatic check_entry(input entry_t e, input mem_rsp_t got);
        logic [7:0] widx;
        logic       err;
        mem_rsp_t   exp;
        axi_w_t     exp_w;
        widx = e.addr[9:2];
        err  = e.addr[31];
        exp  = '{gnt: 1'b0, valid: 1'b1, rdata: '0, error: err};
        if (e.we) begin
            if (!err) begin
                ref_mem[widx] = merge_bytes(ref_mem[widx], swap_bytes(e.wdata),
                                            swap_strb(e.be));
            end
            exp_w = '{valid: 1'b1, data: swap_bytes(e.wdata), strb: swap_strb(e.be)};
            check_axi_w("data_axi_o.w", last_w_q, exp_w);
        end else begin
            exp.rdata = swap_bytes(ref_mem[widx]);
        end
        check_rsp(e.port ? "data_rsp_o" : "instr_rsp_o", got, exp, !e.we && !err);
    endtask

    // Next request is presented while the current one is still open
    task automatic run_port(input bit port);
        int sel [$];
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (stim[i].port == port) sel.push_back(i);
        end
        @(negedge clk);
        if (sel.size() > 0) drive_req(port, stim[sel[0]]);
        for (int k = 0; k < sel.size(); k++) begin
            wait_gnt(port);
            if (k + 1 < sel.size()) drive_req(port, stim[sel[k+1]]);
            else core_req[port] = '0;
            wait_valid(port);
            check_entry(stim[sel[k]], seen_q[port]);
        end
    endtask

    initial begin
        core_req = '0;
        reset    = 1'b1;
        load_stimulus();
        for (int i = 0; i < 256; i++) ref_mem[i] = fill_word(8'(i));
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_idle();
        fork
            run_port(1'b0);
            run_port(1'b1);
        join
        if (gnt_cnt[0] + gnt_cnt[1] == N_ENTRIES && valid_cnt[0] + valid_cnt[1] == N_ENTRIES) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure("Number of grants or valids does not match the table");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
hw/socket_mem_pkg.sv
hw/socket_axi_pkg.sv
hw/axi_read_channel.sv
hw/axi_write_channel.sv
hw/mem_to_axi_bridge.sv
hw/mem_axi_socket.sv
dv/axi_mem_model.sv
dv/socket_tb.sv

/* Makefile */
# Verilator build and run of the socket testbench

TOP = socket_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
